/* verif/forth_testdata.hex */
// 16-bit words. 000: len1 len2 reads writes1 writes2. 010 and 100: program bytes
// 180: read pairs (address data). 200 and 280: expected write pairs (address data)
@000
00D2 0061 0002 0011 0008
@010
00 34 12 00 0F 0F F0 00 00 01 02 00 00 10 00 01 00 F1 00 01 01 02 // add, sub
00 F0 F0 00 3C 3C F2 00 02 01 02 00 00 0F 00 A5 00 F3 00 03 01 02 // and, or
00 AA AA 00 FF FF F4 00 04 01 02 00 81 00 00 04 00 FB 00 05 01 02 // xor, shl
00 00 80 00 0F 00 FC 00 06 01 02                                  // shr
00 11 00 00 22 00 00 33 00 0D 10 0E 01                            // drop over swap dup
00 10 01 02 00 11 01 02 00 12 01 02 00 13 01 02
03 74 00 00 AD DE 00 FF 01 02                                     // jmp over marker
00 01 00 0A 81 00 00 AD DE 00 FF 01 02                            // br taken
00 00 00 0A 8E 00 00 01 0B 00 20 01 02                            // br not taken
00 00 00 0B 9B 00 00 AD DE 00 FF 01 02                            // br0 taken
00 05 00 0B A8 00 00 02 0B 00 21 01 02                            // br0 not taken
05 CA 00 00 02 0C 00 31 01 02                                     // call, store after ret
00 40 01 04 00 41 01 02 00 42 01 04 00 43 01 02                   // get, set back
08 00 AD DE 00 FF 01 02                                           // hlt, dead marker
00 01 0C 00 30 01 02 06                                           // subroutine at CA
@100
00 34 12 00 34 12 F5 00 00 02 02 00 34 12 00 34 12 F6 00 01 02 02 // eq, ne
00 05 00 00 03 00 F7 00 02 02 02 00 03 00 00 05 00 F8 00 03 02 02 // gt, ge
00 07 00 00 07 00 F9 00 04 02 02 00 09 00 00 02 00 FA 00 05 02 02 // le, lt
00 20 00 00 05 00 FD 00 06 02 02 00 20 00 00 04 00 FD 00 07 02 02 // bit set, bit clear
FE 00 AD DE 00 FF 01 02 08                                        // undefined opcode
@180
0140 5A3C 0142 C3A5
@200
0100 2143 0101 0FFF 0102 3030 0103 0FA5
0104 5555 0105 0810 0106 0001
0110 0022 0111 0022 0112 0011 0113 0011
0120 0B01 0121 0B02 0130 0C01 0131 0C02
0141 5A3C 0143 C3A5
@280
0200 0001 0201 0000 0202 0001 0203 0000
0204 0001 0205 0000 0206 0001 0207 0000

/* compile.f */
+incdir+common
common/forth_pkg.sv
common/stack_if.sv
source/program_rom.sv
source/data_stack.sv
source/call_stack.sv
core/forth_alu.sv
core/forth_control.sv
source/forth_cpu.sv
verif/forth_tb_sva.sv
verif/forth_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module forth_tb -f compile.f

status=0
./obj_dir/Vforth_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"

/* verif/forth_tb.sv */
`default_nettype none

module forth_tb;

    localparam int MAX_INSTR    = 100;             // longest program rounded up
    localparam int CYCLE_LIMIT  = 20 * MAX_INSTR;
    localparam int RESET_CYCLES = 10;
    localparam int TAIL_CYCLES  = 20;              // watch for stray writes after stop
    localparam int PROG1_BASE   = 'h010;
    localparam int PROG2_BASE   = 'h100;
    localparam int READ_BASE    = 'h180;
    localparam int WR1_BASE     = 'h200;
    localparam int WR2_BASE     = 'h280;

    logic                 clk;
    logic                 nreset;
    logic                 prog_we;
    forth_pkg::rom_addr_t prog_addr;
    forth_pkg::ins_t      prog_data;
    forth_pkg::word_t     mem_address;
    forth_pkg::word_t     mem_data_out;
    forth_pkg::word_t     mem_data_in;
    logic                 mem_valid;
    logic                 mem_nwr;
    logic                 mem_ready;
    logic                 hlt;
    logic                 error;

    forth_pkg::word_t tdata [0:'h2FF];
    string            prog_name;
    int               n_checks;
    int               n_errors;
    int               cycle_cnt;
    int               rd_idx;
    int               wr_idx;
    int               wr_base;
    int               wr_count;
    int               wait_left;
    logic             wait_armed;
    forth_pkg::word_t xfer_addr;
    forth_pkg::word_t xfer_data;
    logic             xfer_nwr;

    forth_cpu forth_cpu_i (
        .clk          (clk),
        .nreset       (nreset),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .mem_address  (mem_address),
        .mem_data_out (mem_data_out),
        .mem_data_in  (mem_data_in),
        .mem_valid    (mem_valid),
        .mem_nwr      (mem_nwr),
        .mem_ready    (mem_ready),
        .hlt          (hlt),
        .error        (error)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_word(input string name, input forth_pkg::word_t exp,
                              input forth_pkg::word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end else begin
            $display("ok %s: %h", name, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end else begin
            $display("ok %s: %b", name, act);
        end
    endtask

    task automatic report_failure(input string msg);
        n_checks++;
        n_errors++;
        $display("%s", msg);
    endtask

    task automatic record_write(input forth_pkg::word_t addr, input forth_pkg::word_t data);
        string tag;
        tag = $sformatf("%s_write%0d", prog_name, wr_idx);
        if (wr_idx >= wr_count) begin
            report_failure($sformatf("%s: unexpected write of %h to address %h",
                                     prog_name, data, addr));
        end else begin
            check_word({tag, "_addr"}, tdata[wr_base + 2 * wr_idx], addr);
            check_word({tag, "_data"}, tdata[wr_base + 2 * wr_idx + 1], data);
        end
        wr_idx++;
    endtask

    task automatic serve_read(input forth_pkg::word_t addr);
        if (rd_idx >= int'(tdata[2])) begin
            report_failure($sformatf("%s: unexpected read from address %h", prog_name, addr));
            mem_data_in = '0;
        end else begin
            check_word($sformatf("read%0d_addr", rd_idx), tdata[READ_BASE + 2 * rd_idx], addr);
            mem_data_in = tdata[READ_BASE + 2 * rd_idx + 1];
        end
        rd_idx++;
    endtask

    // memory model with 0 to 5 cycles of ready delay
    initial begin
        void'($urandom(15));
        mem_ready   = 1'b0;
        mem_data_in = '0;
        wait_armed  = 1'b0;
        wait_left   = 0;
        rd_idx      = 0;
        forever begin
            @(negedge clk);
            if (!nreset) begin
                mem_ready  = 1'b0;
                wait_armed = 1'b0;
            end else if (mem_ready) begin
                mem_ready  = 1'b0; // transfer closed on the last edge
                wait_armed = 1'b0;
                if (!xfer_nwr) begin
                    record_write(xfer_addr, xfer_data);
                end
            end else if (mem_valid) begin
                if (!wait_armed) begin
                    wait_left  = int'($urandom % 6);
                    wait_armed = 1'b1;
                end
                if (wait_left == 0) begin
                    mem_ready = 1'b1;
                    xfer_addr = mem_address;
                    xfer_data = mem_data_out;
                    xfer_nwr  = mem_nwr;
                    if (mem_nwr) begin
                        serve_read(mem_address);
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic run_program(input string name, input int prog_base, input int prog_len,
                               input int exp_base, input int exp_count, input logic exp_hlt);
        @(negedge clk);
        nreset    = 1'b0;
        prog_name = name;
        wr_base   = exp_base;
        wr_count  = exp_count;
        wr_idx    = 0;
        for (int i = 0; i < prog_len; i++) begin
            prog_we   = 1'b1;
            prog_addr = forth_pkg::rom_addr_t'(i);
            prog_data = tdata[prog_base + i][7:0];
            @(negedge clk);
        end
        prog_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        nreset = 1'b1;
        while (!hlt && !error) @(negedge clk);
        repeat (TAIL_CYCLES) @(negedge clk);
        check_flag({name, "_hlt"}, exp_hlt, hlt);
        check_flag({name, "_error"}, !exp_hlt, error);
        check_flag({name, "_mem_valid"}, 1'b0, mem_valid);
        if (wr_idx < wr_count) begin
            report_failure($sformatf("%s: only %0d of %0d expected writes seen",
                                     name, wr_idx, wr_count));
        end
    endtask

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            if (!nreset) begin
                cycle_cnt = 0;
            end else begin
                cycle_cnt++;
            end
        end
        $display("timeout: program still running after %0d cycles", CYCLE_LIMIT);
        $display("Test failures found");
        $finish;
    end

    initial begin
        nreset    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        n_checks  = 0;
        n_errors  = 0;
        wr_idx    = 0;
        wr_base   = WR1_BASE;
        wr_count  = 0;
        prog_name = "none";
        $readmemh("verif/forth_testdata.hex", tdata);
        run_program("prog1", PROG1_BASE, int'(tdata[0]), WR1_BASE, int'(tdata[3]), 1'b1);
        run_program("prog2", PROG2_BASE, int'(tdata[1]), WR2_BASE, int'(tdata[4]), 1'b0);
        if (rd_idx != int'(tdata[2])) begin
            report_failure($sformatf("only %0d of %0d expected reads seen",
                                     rd_idx, int'(tdata[2])));
        end
        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/forth_tb_sva.sv */
`default_nettype none

module forth_tb_sva (
    input logic             clk,
    input logic             nreset,
    input logic             mem_valid,
    input logic             mem_nwr,
    input logic             mem_ready,
    input forth_pkg::word_t mem_address,
    input forth_pkg::word_t mem_data_out,
    input logic             hlt,
    input logic             error
);

    a_reset_idle: assert property (@(posedge clk)
        !nreset |=> !mem_valid && mem_nwr && !hlt && !error)
        else $error("memory port or status not idle after reset");

    a_hold_request: assert property (@(posedge clk) disable iff (!nreset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_address) && $stable(mem_nwr)
            && $stable(mem_data_out))
        else $error("memory request changed before mem_ready");

    a_release: assert property (@(posedge clk) disable iff (!nreset)
        mem_valid && mem_ready |=> !mem_valid && mem_nwr)
        else $error("mem_valid still high after completed transfer");

    a_hlt_held: assert property (@(posedge clk) disable iff (!nreset) hlt |=> hlt)
        else $error("hlt fell without reset");

    a_quiet_after_stop: assert property (@(posedge clk) disable iff (!nreset)
        hlt || error |-> !mem_valid)
        else $error("memory request after hlt or error");

endmodule

bind forth_control forth_tb_sva forth_tb_sva_i (
    .clk          (clk),
    .nreset       (nreset),
    .mem_valid    (mem_valid),
    .mem_nwr      (mem_nwr),
    .mem_ready    (mem_ready),
    .mem_address  (mem_address),
    .mem_data_out (mem_data_out),
    .hlt          (hlt),
    .error        (error)
);

`default_nettype wire

/* source/forth_cpu.sv */
`default_nettype none

module forth_cpu (
    input  logic                 clk,
    input  logic                 nreset,
    input  logic                 prog_we,
    input  forth_pkg::rom_addr_t prog_addr,
    input  forth_pkg::ins_t      prog_data,
    output forth_pkg::word_t     mem_address,
    output forth_pkg::word_t     mem_data_out,
    input  forth_pkg::word_t     mem_data_in,
    output logic                 mem_valid,
    output logic                 mem_nwr,
    input  logic                 mem_ready,
    output logic                 hlt,
    output logic                 error
);

    forth_pkg::rom_addr_t fetch_addr;
    forth_pkg::ins_t      fetch_data;
    logic                 cs_push;
    logic                 cs_pop;
    forth_pkg::word_t     cs_wr_data;
    forth_pkg::word_t     cs_top;

    stack_if ds_bus ();

    program_rom program_rom_i (
        .clk     (clk),
        .we      (prog_we),
        .wr_addr (prog_addr),
        .wr_data (prog_data),
        .rd_addr (fetch_addr),
        .rd_data (fetch_data)
    );

    data_stack data_stack_i (
        .clk    (clk),
        .nreset (nreset),
        .st     (ds_bus.stack)
    );

    call_stack call_stack_i (
        .clk     (clk),
        .nreset  (nreset),
        .push    (cs_push),
        .pop     (cs_pop),
        .wr_data (cs_wr_data),
        .top     (cs_top)
    );

    forth_control forth_control_i (
        .clk          (clk),
        .nreset       (nreset),
        .rom_addr     (fetch_addr),
        .rom_data     (fetch_data),
        .ds           (ds_bus.control),
        .cs_push      (cs_push),
        .cs_pop       (cs_pop),
        .cs_wr_data   (cs_wr_data),
        .cs_top       (cs_top),
        .mem_address  (mem_address),
        .mem_data_out (mem_data_out),
        .mem_data_in  (mem_data_in),
        .mem_valid    (mem_valid),
        .mem_nwr      (mem_nwr),
        .mem_ready    (mem_ready),
        .hlt          (hlt),
        .error        (error)
    );

endmodule

`default_nettype wire

/* core/forth_control.sv */
`default_nettype none

`include "forth_settings.svh"

module forth_control (
    input  logic                 clk,
    input  logic                 nreset,
    output forth_pkg::rom_addr_t rom_addr,
    input  forth_pkg::ins_t      rom_data,
    stack_if.control             ds,
    output logic                 cs_push,
    output logic                 cs_pop,
    output forth_pkg::word_t     cs_wr_data,
    input  forth_pkg::word_t     cs_top,
    output forth_pkg::word_t     mem_address,
    output forth_pkg::word_t     mem_data_out,
    input  forth_pkg::word_t     mem_data_in,
    output logic                 mem_valid,
    output logic                 mem_nwr,
    input  logic                 mem_ready,
    output logic                 hlt,
    output logic                 error
);

    forth_pkg::ctrl_state_t state;
    forth_pkg::word_t       pc;
    forth_pkg::ins_t        instr;
    forth_pkg::ins_t        lo_byte;
    forth_pkg::word_t       swap_word;
    forth_pkg::alu_op_t     alu_op;
    forth_pkg::word_t       alu_result;
    forth_pkg::word_t       target;

    logic op_push, op_dup, op_set, op_jmp, op_get, op_call, op_ret;
    logic op_hlt, op_br, op_br0, op_drop, op_swap, op_over, op_alu;
    logic br_taken;

    assign op_push = instr == `FORTH_OP_PUSH;
    assign op_dup  = instr == `FORTH_OP_DUP;
    assign op_set  = instr == `FORTH_OP_SET;
    assign op_jmp  = instr == `FORTH_OP_JMP;
    assign op_get  = instr == `FORTH_OP_GET;
    assign op_call = instr == `FORTH_OP_CALL;
    assign op_ret  = instr == `FORTH_OP_RET;
    assign op_hlt  = instr == `FORTH_OP_HLT;
    assign op_br   = instr == `FORTH_OP_BR;
    assign op_br0  = instr == `FORTH_OP_BR0;
    assign op_drop = instr == `FORTH_OP_DROP;
    assign op_swap = instr == `FORTH_OP_SWAP;
    assign op_over = instr == `FORTH_OP_OVER;

    assign alu_op = forth_pkg::alu_op_t'(instr[3:0]);
    assign op_alu = (instr[7:4] == `FORTH_ALU_PREFIX)
                    && (alu_op <= forth_pkg::ALU_BIT); // FE, FF undefined

    assign br_taken = (op_br && ds.top != '0) || (op_br0 && ds.top == '0);

    assign rom_addr   = pc[`FORTH_ROM_BITS-1:0];
    assign target     = {rom_data, lo_byte}; // valid in fetch2
    assign cs_wr_data = pc + 16'd2;          // skip both operand bytes

    forth_alu forth_alu_i (
        .op     (alu_op),
        .a      (ds.next),
        .b      (ds.top),
        .result (alu_result)
    );

    // stack requests act on the edge closing the cycle
    always_comb begin
        ds.push    = 1'b0;
        ds.pop     = 1'b0;
        ds.pop2    = 1'b0;
        ds.write   = 1'b0;
        ds.wr_data = '0;
        cs_push    = 1'b0;
        cs_pop     = 1'b0;
        case (state)
            forth_pkg::ST_DECODE: begin
                if (op_dup || op_over) begin
                    ds.push    = 1'b1;
                    ds.wr_data = op_dup ? ds.top : ds.next;
                end else if (op_drop || op_br || op_br0) begin
                    ds.pop = 1'b1;
                end else if (op_swap) begin
                    ds.pop     = 1'b1; // old top lands in the next slot
                    ds.write   = 1'b1;
                    ds.wr_data = ds.top;
                end else if (op_alu) begin
                    ds.pop     = 1'b1;
                    ds.write   = 1'b1;
                    ds.wr_data = alu_result;
                end else if (op_set) begin
                    ds.pop2 = 1'b1;
                end
                cs_push = op_call;
                cs_pop  = op_ret;
            end
            forth_pkg::ST_FETCH2: begin
                ds.push    = op_push;
                ds.wr_data = target;
            end
            forth_pkg::ST_SWAP2: begin
                ds.push    = 1'b1;
                ds.wr_data = swap_word;
            end
            forth_pkg::ST_WAITREADY: begin
                ds.write   = mem_ready && op_get; // address replaced by data
                ds.wr_data = mem_data_in;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state     <= forth_pkg::ST_FETCH;
            pc        <= '0;
            instr     <= '0;
            mem_valid <= 1'b0;
            mem_nwr   <= 1'b1;
            hlt       <= 1'b0;
            error     <= 1'b0;
        end else begin
            case (state)
                forth_pkg::ST_FETCH: begin
                    instr <= rom_data;
                    pc    <= pc + 1'b1;
                    state <= forth_pkg::ST_DECODE;
                end
                forth_pkg::ST_DECODE: begin
                    state <= forth_pkg::ST_FETCH;
                    if (op_push || op_jmp || op_call || br_taken) begin
                        pc    <= pc + 1'b1;
                        state <= forth_pkg::ST_FETCH2;
                    end else if (op_br || op_br0) begin
                        pc <= pc + 16'd2; // not taken
                    end else if (op_ret) begin
                        pc <= cs_top;
                    end else if (op_swap) begin
                        state <= forth_pkg::ST_SWAP2;
                    end else if (op_get || op_set) begin
                        mem_valid <= 1'b1;
                        mem_nwr   <= !op_set;
                        state     <= forth_pkg::ST_WAITREADY;
                    end else if (op_hlt) begin
                        hlt   <= 1'b1;
                        state <= forth_pkg::ST_HALTED;
                    end else if (!(op_dup || op_over || op_drop || op_alu)) begin
                        error <= 1'b1;
                        state <= forth_pkg::ST_HALTED;
                    end
                end
                forth_pkg::ST_FETCH2: begin
                    pc    <= op_push ? pc + 1'b1 : target;
                    state <= forth_pkg::ST_FETCH;
                end
                forth_pkg::ST_WAITREADY: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        mem_nwr   <= 1'b1;
                        state     <= forth_pkg::ST_FETCH;
                    end
                end
                forth_pkg::ST_SWAP2: state <= forth_pkg::ST_FETCH;
                default: state <= forth_pkg::ST_HALTED; // stays until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == forth_pkg::ST_DECODE) begin
            lo_byte   <= rom_data;
            swap_word <= ds.next;
            if (op_get || op_set) begin
                mem_address  <= ds.top;
                mem_data_out <= ds.next;
            end
        end
    end

endmodule

`default_nettype wire

/* core/forth_alu.sv */
`default_nettype none

`include "forth_settings.svh"

module forth_alu (
    input  forth_pkg::alu_op_t op,
    input  forth_pkg::word_t   a,
    input  forth_pkg::word_t   b,
    output forth_pkg::word_t   result
);

    logic eq;
    logic gt;
    logic flag;

    assign eq = a == b;
    assign gt = a > b; // unsigned compare

    always_comb begin
        case (op)
            forth_pkg::ALU_EQ:  flag = eq;
            forth_pkg::ALU_NE:  flag = !eq;
            forth_pkg::ALU_GT:  flag = gt;
            forth_pkg::ALU_GE:  flag = eq | gt;
            forth_pkg::ALU_LE:  flag = !gt;
            forth_pkg::ALU_LT:  flag = !eq & !gt;
            forth_pkg::ALU_BIT: flag = a[b[3:0]];
            default:            flag = 1'b0;
        endcase
    end

    always_comb begin
        case (op)
            forth_pkg::ALU_ADD: result = a + b;
            forth_pkg::ALU_SUB: result = a - b;
            forth_pkg::ALU_AND: result = a & b;
            forth_pkg::ALU_OR:  result = a | b;
            forth_pkg::ALU_XOR: result = a ^ b;
            forth_pkg::ALU_SHL: result = a << b;
            forth_pkg::ALU_SHR: result = a >> b;
            forth_pkg::ALU_EQ, forth_pkg::ALU_NE, forth_pkg::ALU_GT, forth_pkg::ALU_GE,
            forth_pkg::ALU_LE, forth_pkg::ALU_LT, forth_pkg::ALU_BIT:
                result = {{(`FORTH_WIDTH - 1){1'b0}}, flag};
            default:            result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/call_stack.sv */
`default_nettype none

`include "forth_settings.svh"

module call_stack (
    input  logic             clk,
    input  logic             nreset,
    input  logic             push,
    input  logic             pop,
    input  forth_pkg::word_t wr_data,
    output forth_pkg::word_t top
);

    forth_pkg::word_t   mem [0:(1 << `FORTH_CS_BITS) - 1];
    forth_pkg::cs_ptr_t ptr;
    forth_pkg::cs_ptr_t ptr_dn;

    assign ptr_dn = ptr - 1'b1;

    always_ff @(posedge clk) begin
        if (!nreset) begin
            ptr <= '0;
        end else if (push) begin
            ptr <= ptr_dn;
        end else if (pop) begin
            ptr <= ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[ptr_dn] <= wr_data; // return address
        end
    end

    assign top = mem[ptr];

endmodule

`default_nettype wire

/* source/data_stack.sv */
`default_nettype none

`include "forth_settings.svh"

module data_stack (
    input  logic    clk,
    input  logic    nreset,
    stack_if.stack  st
);

    forth_pkg::word_t  mem [0:(1 << `FORTH_DS_BITS) - 1];
    forth_pkg::ds_ptr_t ptr;
    forth_pkg::ds_ptr_t ptr_up;
    forth_pkg::ds_ptr_t ptr_up2;
    forth_pkg::ds_ptr_t ptr_dn;

    assign ptr_up  = ptr + 1'b1;
    assign ptr_up2 = ptr + 2'd2;
    assign ptr_dn  = ptr - 1'b1;

    // grows downward
    always_ff @(posedge clk) begin
        if (!nreset) begin
            ptr <= '0;
        end else if (st.push) begin
            ptr <= ptr_dn;
        end else if (st.pop2) begin
            ptr <= ptr_up2;
        end else if (st.pop) begin
            ptr <= ptr_up;
        end
    end

    always_ff @(posedge clk) begin
        if (st.push) begin
            mem[ptr_dn] <= st.wr_data;
        end else if (st.pop && st.write) begin
            mem[ptr_up] <= st.wr_data; // two operands become one result
        end else if (st.write) begin
            mem[ptr] <= st.wr_data;    // replace top in place
        end
    end

    assign st.top  = mem[ptr];
    assign st.next = mem[ptr_up];

endmodule

`default_nettype wire

/* source/program_rom.sv */
`default_nettype none

`include "forth_settings.svh"

module program_rom (
    input  logic                 clk,
    input  logic                 we,
    input  forth_pkg::rom_addr_t wr_addr,
    input  forth_pkg::ins_t      wr_data,
    input  forth_pkg::rom_addr_t rd_addr,
    output forth_pkg::ins_t      rd_data
);

    forth_pkg::ins_t mem [0:(1 << `FORTH_ROM_BITS) - 1];

    // load port writes in and out of reset
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    assign rd_data = mem[rd_addr]; // async so operands are visible in decode

endmodule

`default_nettype wire

/* common/stack_if.sv */
`default_nettype none

interface stack_if;

    logic             push;
    logic             pop;
    logic             pop2;    // drop two entries at once
    logic             write;
    forth_pkg::word_t wr_data;
    forth_pkg::word_t top;
    forth_pkg::word_t next;

    modport control (
        output push, pop, pop2, write, wr_data,
        input  top, next
    );

    modport stack (
        input  push, pop, pop2, write, wr_data,
        output top, next
    );

endinterface

`default_nettype wire

/* common/forth_pkg.sv */
`default_nettype none

`include "forth_settings.svh"

package forth_pkg;

    typedef logic [`FORTH_WIDTH-1:0]    word_t;
    typedef logic [7:0]                 ins_t;
    typedef logic [`FORTH_ROM_BITS-1:0] rom_addr_t;
    typedef logic [`FORTH_DS_BITS-1:0]  ds_ptr_t;
    typedef logic [`FORTH_CS_BITS-1:0]  cs_ptr_t;

    // low nibble of the Fx opcodes
    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_EQ  = 4'd5,
        ALU_NE  = 4'd6,
        ALU_GT  = 4'd7,
        ALU_GE  = 4'd8,
        ALU_LE  = 4'd9,
        ALU_LT  = 4'd10,
        ALU_SHL = 4'd11,
        ALU_SHR = 4'd12,
        ALU_BIT = 4'd13
    } alu_op_t;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_FETCH2,    // high operand byte
        ST_WAITREADY,
        ST_SWAP2,
        ST_HALTED
    } ctrl_state_t;

endpackage

`default_nettype wire

/* common/forth_settings.svh */
`ifndef FORTH_SETTINGS_SVH
`define FORTH_SETTINGS_SVH

`define FORTH_WIDTH    16
`define FORTH_DS_BITS  6
`define FORTH_CS_BITS  6
`define FORTH_ROM_BITS 8

`define FORTH_OP_PUSH  8'h00 // followed by lo, hi
`define FORTH_OP_DUP   8'h01
`define FORTH_OP_SET   8'h02
`define FORTH_OP_JMP   8'h03
`define FORTH_OP_GET   8'h04
`define FORTH_OP_CALL  8'h05
`define FORTH_OP_RET   8'h06
`define FORTH_OP_HLT   8'h08
`define FORTH_OP_BR    8'h0A
`define FORTH_OP_BR0   8'h0B
`define FORTH_OP_DROP  8'h0D
`define FORTH_OP_SWAP  8'h0E
`define FORTH_OP_OVER  8'h10
`define FORTH_ALU_PREFIX 4'hF

`endif
